// File: compile.f
verilog/tile_ctrl_pkg.sv
verilog/narrow_beat_if.sv
verilog/apb_if.sv
verilog/dw_split_stage.sv
verilog/beat_cut_stage.sv
verilog/apb_bridge_stage.sv
verilog/hwpe_ctrl_regs.sv
verilog/hwpe_ctrl_tile.sv
verification/tb_clk_gen.sv
verification/hwpe_ctrl_tile_tb.sv

// File: Bender.yml
package:
  name: hwpe_ctrl_tile

sources:
  - files:
      - verilog/tile_ctrl_pkg.sv
      - verilog/narrow_beat_if.sv
      - verilog/apb_if.sv
      - verilog/dw_split_stage.sv
      - verilog/beat_cut_stage.sv
      - verilog/apb_bridge_stage.sv
      - verilog/hwpe_ctrl_regs.sv
      - verilog/hwpe_ctrl_tile.sv
  - target: test
    files:
      - verification/tb_clk_gen.sv
      - verification/hwpe_ctrl_tile_tb.sv

// File: verification/hwpe_ctrl_tile_tb.sv
/*
  Directed testbench for the accelerator control tile. Each test drives
  64-bit accesses on the narrow port and checks the responses and event
  lines against a small register model kept here.
*/

module hwpe_ctrl_tile_tb
  import tile_ctrl_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  // About 60 accesses of 12 cycles plus 10 jobs, five times over
  localparam int unsigned MaxAccesses   = 60;
  localparam int unsigned AccessCycles  = 12;
  localparam int unsigned MaxJobs       = 10;
  localparam int unsigned TimeoutCycles =
    5 * (MaxAccesses * AccessCycles + MaxJobs * JobCycles);
  localparam int unsigned MaxPolls      = 20;
  localparam logic [AddrWidth-1:0] UnmappedAddr = 32'h0000_0040;

  logic                       clk, rst_n;
  logic                       req_valid, req_ready, req_write;
  logic [AddrWidth-1:0]       req_addr;
  logic [NarrowDataWidth-1:0] req_wdata;
  logic [NarrowStrbWidth-1:0] req_strb;
  logic                       rsp_valid, rsp_ready, rsp_error;
  logic [NarrowDataWidth-1:0] rsp_rdata;
  logic [NrCores-1:0]         evt;

  // Last response and the register model
  logic [NarrowDataWidth-1:0] got_rdata;
  logic                       got_err;
  logic [NarrowDataWidth-1:0] exp_operands;
  logic [BeatDataWidth-1:0]   exp_result;
  logic [NrCores-1:0]         exp_mask;

  logic [31:0] rng_state = 32'h3f62;
  string       cur_test;
  int unsigned test_errors, pass_count, fail_count;
  int unsigned cycle_count = 0;

  tb_clk_gen i_clk_gen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  hwpe_ctrl_tile dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .req_valid_i (req_valid),
    .req_ready_o (req_ready),
    .req_write_i (req_write),
    .req_addr_i  (req_addr),
    .req_wdata_i (req_wdata),
    .req_strb_i  (req_strb),
    .rsp_valid_o (rsp_valid),
    .rsp_ready_i (rsp_ready),
    .rsp_rdata_o (rsp_rdata),
    .rsp_error_o (rsp_error),
    .evt_o       (evt)
  );

  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TimeoutCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", TimeoutCycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] rand_word();
    rng_state = xorshift32(rng_state);
    return rng_state;
  endfunction

  // Byte lanes with a set strobe take the new value
  function automatic logic [NarrowDataWidth-1:0] merge_bytes(
    input logic [NarrowDataWidth-1:0] old_val,
    input logic [NarrowDataWidth-1:0] new_val,
    input logic [NarrowStrbWidth-1:0] strb
  );
    logic [NarrowDataWidth-1:0] res;
    res = old_val;
    for (int i = 0; i < NarrowStrbWidth; i++) begin
      if (strb[i]) res[8*i +: 8] = new_val[8*i +: 8];
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Compare tasks and bookkeeping
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_data(input string what, input logic [NarrowDataWidth-1:0] exp_val,
                            input logic [NarrowDataWidth-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("Error: %s %s expected %h actual %h", cur_test, what, exp_val, act_val);
      test_errors++;
    end
  endtask

  task automatic check_error(input string what, input logic exp_val, input logic act_val);
    if (act_val !== exp_val) begin
      $display("Error: %s %s expected %b actual %b", cur_test, what, exp_val, act_val);
      test_errors++;
    end
  endtask

  task automatic check_evt(input string what, input logic [NrCores-1:0] exp_val,
                           input logic [NrCores-1:0] act_val);
    if (act_val !== exp_val) begin
      $display("Error: %s %s expected %b actual %b", cur_test, what, exp_val, act_val);
      test_errors++;
    end
  endtask

  task automatic begin_test(input string name);
    cur_test    = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    if (test_errors == 0) begin
      pass_count++;
      $display("[pass] %s", cur_test);
    end else begin
      fail_count++;
      $display("[fail] %s with %0d errors", cur_test, test_errors);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Bus access
  ////////////////////////////////////////////////////////////////////////////

  // One 64-bit access; hold keeps rsp_ready low that many cycles
  task automatic bus_access(input logic write, input logic [AddrWidth-1:0] addr,
                            input logic [NarrowDataWidth-1:0] wdata,
                            input logic [NarrowStrbWidth-1:0] strb,
                            input int unsigned hold);
    req_valid <= 1'b1;
    req_write <= write;
    req_addr  <= addr;
    req_wdata <= wdata;
    req_strb  <= strb;
    rsp_ready <= (hold == 0);
    do @(posedge clk); while (req_ready !== 1'b1);
    req_valid <= 1'b0;
    do @(posedge clk); while (rsp_valid !== 1'b1);
    got_rdata = rsp_rdata;
    got_err   = rsp_error;
    if (hold != 0) begin
      repeat (hold) begin
        @(posedge clk);
        if (rsp_valid !== 1'b1 || req_ready !== 1'b0 ||
            rsp_rdata !== got_rdata || rsp_error !== got_err) begin
          $display("In %s the held response changed or a new request was taken", cur_test);
          test_errors++;
        end
      end
      rsp_ready <= 1'b1;
      @(posedge clk);
    end
  endtask

  task automatic do_write(input logic [AddrWidth-1:0] addr,
                          input logic [NarrowDataWidth-1:0] wdata,
                          input logic [NarrowStrbWidth-1:0] strb);
    bus_access(1'b1, addr, wdata, strb, 0);
  endtask

  task automatic do_read(input logic [AddrWidth-1:0] addr, input int unsigned hold);
    bus_access(1'b0, addr, '0, '0, hold);
  endtask

  // Busy is bit 0 of the status word, the upper half of the control pair
  task automatic wait_job_idle();
    int unsigned polls;
    polls = 0;
    do begin
      do_read(RegCtrl, 0);
      check_error("status read error", 1'b0, got_err);
      polls++;
    end while (got_rdata[BeatDataWidth] !== 1'b0 && polls < MaxPolls);
    if (got_rdata[BeatDataWidth] !== 1'b0) begin
      $display("In %s the job was still busy after %0d status reads", cur_test, polls);
      test_errors++;
    end
  endtask

  task automatic start_job();
    do_write(RegCtrl, 64'h1, 8'h0F);
    check_error("start error", 1'b0, got_err);
  endtask

  task automatic write_operands();
    logic [NarrowDataWidth-1:0] data;
    data[63:32] = rand_word();
    data[31:0]  = rand_word();
    do_write(RegOperand0, data, '1);
    check_error("operand write error", 1'b0, got_err);
    exp_operands = data;
  endtask

  function automatic logic [NarrowDataWidth-1:0] result_pair();
    return {{(BeatDataWidth - NrCores){1'b0}}, exp_mask, exp_result};
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////////////

  task automatic test_write_readback();
    begin_test("write_readback");
    write_operands();
    do_read(RegOperand0, 0);
    check_error("read error", 1'b0, got_err);
    check_data("operand pair", exp_operands, got_rdata);
    end_test();
  endtask

  task automatic test_strobe_merge();
    logic [NarrowDataWidth-1:0] data;
    begin_test("strobe_merge");
    data = {rand_word(), 32'h0};
    data[31:0] = rand_word();
    do_write(RegOperand0, data, 8'hF0);
    exp_operands = merge_bytes(exp_operands, data, 8'hF0);
    do_read(RegOperand0, 0);
    check_data("upper only", exp_operands, got_rdata);
    data[63:32] = rand_word();
    data[31:0]  = rand_word();
    do_write(RegOperand0, data, 8'h04);
    check_error("byte write error", 1'b0, got_err);
    exp_operands = merge_bytes(exp_operands, data, 8'h04);
    do_read(RegOperand0, 0);
    check_data("single byte", exp_operands, got_rdata);
    end_test();
  endtask

  task automatic test_job_sum();
    logic [BeatDataWidth-1:0] new_op0;
    begin_test("job_sum");
    write_operands();
    start_job();
    wait_job_idle();
    exp_result = exp_operands[31:0] + exp_operands[63:32];
    do_read(RegResult, 0);
    check_data("result", result_pair(), got_rdata);
    // Second start lands while the first job still runs
    write_operands();
    start_job();
    start_job();
    new_op0 = rand_word();
    do_write(RegOperand0, {32'h0, new_op0}, 8'h0F);
    wait_job_idle();
    exp_result = exp_operands[31:0] + exp_operands[63:32];
    exp_operands[31:0] = new_op0;
    do_read(RegResult, 0);
    check_data("result after start while busy", result_pair(), got_rdata);
    end_test();
  endtask

  task automatic test_event_mask();
    logic [NrCores-1:0] clr;
    begin_test("event_mask");
    do_write(RegEvtClear, 64'hF, 8'h0F);
    exp_mask = NrCores'(rand_word());
    // Mask register is the upper half of the result pair
    do_write(RegEvtMask, {28'h0, exp_mask, 32'h0}, 8'hF0);
    check_error("mask write error", 1'b0, got_err);
    check_evt("nothing pending", '0, evt);
    start_job();
    wait_job_idle();
    exp_result = exp_operands[31:0] + exp_operands[63:32];
    check_evt("after job", exp_mask, evt);
    clr = NrCores'(rand_word());
    do_write(RegEvtClear, {60'h0, clr}, 8'h0F);
    check_evt("after partial clear", exp_mask & ~clr, evt);
    do_read(RegResult, 0);
    check_data("result and mask", result_pair(), got_rdata);
    end_test();
  endtask

  task automatic test_error_response();
    begin_test("error_response");
    do_read(UnmappedAddr, 0);
    check_error("unmapped read", 1'b1, got_err);
    check_data("unmapped read data", '0, got_rdata);
    do_write(UnmappedAddr, {rand_word(), rand_word()}, '1);
    check_error("unmapped write", 1'b1, got_err);
    check_data("unmapped write data", '0, got_rdata);
    do_write(RegResult, {32'h0, rand_word()}, 8'h0F);
    check_error("result write", 1'b1, got_err);
    check_data("result write data", '0, got_rdata);
    do_read(RegOperand0, 0);
    check_data("operands kept", exp_operands, got_rdata);
    do_read(RegResult, 0);
    check_data("result kept", result_pair(), got_rdata);
    end_test();
  endtask

  task automatic test_backpressure();
    int unsigned hold;
    begin_test("backpressure");
    write_operands();
    hold = 2 + rand_word() % 7;
    do_read(RegOperand0, hold);
    check_error("held read error", 1'b0, got_err);
    check_data("held read data", exp_operands, got_rdata);
    do_read(RegResult, 0);
    check_data("read after hold", result_pair(), got_rdata);
    end_test();
  endtask

  initial begin
    req_valid <= 1'b0;
    req_write <= 1'b0;
    req_addr  <= '0;
    req_wdata <= '0;
    req_strb  <= '0;
    rsp_ready <= 1'b1;
    exp_operands = '0;
    exp_result   = '0;
    exp_mask     = '0;
    pass_count   = 0;
    fail_count   = 0;
    do @(posedge clk); while (!rst_n);

    test_write_readback();
    test_strobe_merge();
    test_job_sum();
    test_event_mask();
    test_error_response();
    test_backpressure();

    $display("Summary: %0d tests passed, %0d with errors", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verification/tb_clk_gen.sv
/*
  Testbench clock and reset source. Runs a 10 ns clock and holds the
  synchronous active-low reset for the first five rising edges.
*/

module tb_clk_gen (
  output logic clk_o,
  output logic rst_n_o
);
  timeunit 1ns;
  timeprecision 1ps;

  localparam int unsigned ResetCycles = 5;

  initial begin
    clk_o = 1'b0;
    forever #5 clk_o = ~clk_o;
  end

  initial begin
    rst_n_o = 1'b0;
    repeat (ResetCycles) @(posedge clk_o);
    rst_n_o <= 1'b1;
  end

endmodule

// File: verilog/hwpe_ctrl_tile.sv
/*
  Top of the accelerator control path. Takes 64-bit valid/ready
  accesses from the cluster side and returns the per-core event lines.
*/

module hwpe_ctrl_tile
  import tile_ctrl_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  // Narrow request and response
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic                       req_write_i,
  input  logic [AddrWidth-1:0]       req_addr_i,
  input  logic [NarrowDataWidth-1:0] req_wdata_i,
  input  logic [NarrowStrbWidth-1:0] req_strb_i,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output logic [NarrowDataWidth-1:0] rsp_rdata_o,
  output logic                       rsp_error_o,
  // Accelerator events
  output logic [NrCores-1:0]         evt_o
);

  narrow_beat_if split_beat (.clk_i);
  narrow_beat_if cut_beat (.clk_i);
  apb_if         hwpe_apb ();

  dw_split_stage i_dw_split (
    .clk_i,
    .rst_n_i,
    .req_valid_i,
    .req_ready_o,
    .req_write_i,
    .req_addr_i,
    .req_wdata_i,
    .req_strb_i,
    .rsp_valid_o,
    .rsp_ready_i,
    .rsp_rdata_o,
    .rsp_error_o,
    .beat_o     (split_beat)
  );

  beat_cut_stage i_beat_cut (
    .clk_i,
    .rst_n_i,
    .beat_i (split_beat),
    .beat_o (cut_beat)
  );

  apb_bridge_stage i_apb_bridge (
    .clk_i,
    .rst_n_i,
    .beat_i (cut_beat),
    .apb_o  (hwpe_apb)
  );

  hwpe_ctrl_regs i_hwpe_ctrl (
    .clk_i,
    .rst_n_i,
    .apb_i (hwpe_apb),
    .evt_o
  );

endmodule

// File: verilog/hwpe_ctrl_regs.sv
/*
  Accelerator control block on APB. Holds the job registers, runs the
  fixed-length addition job and raises the masked per-core events.
*/

module hwpe_ctrl_regs
  import tile_ctrl_pkg::*;
(
  input  logic               clk_i,
  input  logic               rst_n_i,
  apb_if.subordinate         apb_i,
  output logic [NrCores-1:0] evt_o
);

  job_state_e               job_state_q;
  logic [JobCntWidth-1:0]   job_cnt_q;
  logic                     busy, start, job_done;
  logic [BeatDataWidth-1:0] operand0_q, operand1_q, result_q;
  logic [NrCores-1:0]       evt_mask_q, evt_pend_q;
  logic [BeatDataWidth-1:0] mask_wr;
  logic [BeatDataWidth-1:0] rdata;
  logic                     addr_ok, read_only;
  logic                     access, err, wr_en;

  function automatic logic [BeatDataWidth-1:0] apply_strb(
    input logic [BeatDataWidth-1:0] old_val,
    input logic [BeatDataWidth-1:0] new_val,
    input logic [BeatStrbWidth-1:0] strb
  );
    logic [BeatDataWidth-1:0] res;
    res = old_val;
    for (int i = 0; i < BeatStrbWidth; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = new_val[8*i +: 8];
      end
    end
    return res;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    rdata     = '0;
    addr_ok   = 1'b1;
    read_only = 1'b0;
    case (apb_i.paddr)
      RegCtrl:     rdata = '0;
      RegStatus: begin
        rdata     = BeatDataWidth'(busy);
        read_only = 1'b1;
      end
      RegOperand0: rdata = operand0_q;
      RegOperand1: rdata = operand1_q;
      RegResult: begin
        rdata     = result_q;
        read_only = 1'b1;
      end
      RegEvtMask:  rdata = BeatDataWidth'(evt_mask_q);
      RegEvtClear: rdata = '0;
      default:     addr_ok = 1'b0;
    endcase
  end

  // Always ready in the first access cycle
  assign access = apb_i.psel && apb_i.penable;
  assign err    = !addr_ok || (apb_i.pwrite && read_only);
  assign wr_en  = access && apb_i.pwrite && !err;

  assign apb_i.pready  = access;
  assign apb_i.pslverr = access && err;
  assign apb_i.prdata  = (access && !apb_i.pwrite && !err) ? rdata : '0;

  assign mask_wr = apply_strb(BeatDataWidth'(evt_mask_q), apb_i.pwdata, apb_i.pstrb);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      operand0_q <= '0;
      operand1_q <= '0;
      evt_mask_q <= '0;
    end else if (wr_en) begin
      if (apb_i.paddr == RegOperand0) begin
        operand0_q <= apply_strb(operand0_q, apb_i.pwdata, apb_i.pstrb);
      end
      if (apb_i.paddr == RegOperand1) begin
        operand1_q <= apply_strb(operand1_q, apb_i.pwdata, apb_i.pstrb);
      end
      if (apb_i.paddr == RegEvtMask) begin
        evt_mask_q <= mask_wr[NrCores-1:0];
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Job engine and events
  ////////////////////////////////////////////////////////////////////////////

  assign busy     = (job_state_q == JOB_RUN);
  // Start while busy is dropped
  assign start    = wr_en && (apb_i.paddr == RegCtrl) && apb_i.pstrb[0] &&
                    apb_i.pwdata[0] && !busy;
  assign job_done = busy && (job_cnt_q == '0);

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      job_state_q <= JOB_IDLE;
      job_cnt_q   <= '0;
      result_q    <= '0;
      evt_pend_q  <= '0;
    end else begin
      if (start) begin
        job_state_q <= JOB_RUN;
        job_cnt_q   <= JobCntWidth'(JobCycles - 1);
      end else if (job_done) begin
        job_state_q <= JOB_IDLE;
        result_q    <= operand0_q + operand1_q;
      end else if (busy) begin
        job_cnt_q <= job_cnt_q - 1'b1;
      end
      if (wr_en && (apb_i.paddr == RegEvtClear) && apb_i.pstrb[0]) begin
        evt_pend_q <= evt_pend_q & ~apb_i.pwdata[NrCores-1:0];
      end
      if (job_done) begin
        evt_pend_q <= '1;
      end
    end
  end

  assign evt_o = evt_pend_q & evt_mask_q;

endmodule

// File: verilog/apb_bridge_stage.sv
/*
  Beat to APB bridge. Each accepted beat becomes one setup and access
  sequence; the response is returned the cycle after pready.
*/

module apb_bridge_stage
  import tile_ctrl_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  narrow_beat_if.responder beat_i,
  apb_if.manager           apb_o
);

  apb_state_e               state_q, state_d;
  logic                     take;
  logic                     done;
  logic                     pwrite_q;
  logic [AddrWidth-1:0]     paddr_q;
  logic [BeatDataWidth-1:0] pwdata_q;
  logic [BeatStrbWidth-1:0] pstrb_q;
  logic                     rsp_valid_q;
  logic [BeatDataWidth-1:0] rsp_rdata_q;
  logic                     rsp_err_q;

  assign take = beat_i.valid && beat_i.ready;
  assign done = (state_q == APB_ACCESS) && apb_o.pready;

  always_comb begin
    state_d = state_q;
    case (state_q)
      APB_IDLE:   if (take) state_d = APB_SETUP;
      APB_SETUP:  state_d = APB_ACCESS;
      APB_ACCESS: if (apb_o.pready) state_d = APB_IDLE;
      default:    state_d = APB_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= APB_IDLE;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      rsp_valid_q <= done;
    end
  end

  always_ff @(posedge clk_i) begin
    if (take) begin
      pwrite_q <= (beat_i.op == BEAT_WRITE);
      paddr_q  <= beat_i.addr;
      pwdata_q <= beat_i.wdata;
      pstrb_q  <= beat_i.strb;
    end
    if (done) begin
      rsp_rdata_q <= apb_o.prdata;
      rsp_err_q   <= apb_o.pslverr;
    end
  end

  assign beat_i.ready = (state_q == APB_IDLE);

  assign apb_o.psel    = (state_q != APB_IDLE);
  assign apb_o.penable = (state_q == APB_ACCESS);
  assign apb_o.pwrite  = pwrite_q;
  assign apb_o.paddr   = paddr_q;
  assign apb_o.pwdata  = pwdata_q;
  assign apb_o.pstrb   = pstrb_q;

  assign beat_i.rsp_valid = rsp_valid_q;
  assign beat_i.rsp_rdata = rsp_rdata_q;
  assign beat_i.rsp_err   = rsp_err_q;

  // Access only with psel, and only after a selected cycle
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   apb_o.penable |-> apb_o.psel && $past(apb_o.psel));
  // Address held from setup until the transfer ends
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   apb_o.psel && !(apb_o.penable && apb_o.pready) |=> $stable(apb_o.paddr));

endmodule

// File: verilog/beat_cut_stage.sv
/*
  Register cut on the beat request path, a small circular buffer that
  breaks the ready path. Responses pass straight back.
*/

module beat_cut_stage
  import tile_ctrl_pkg::*;
(
  input  logic             clk_i,
  input  logic             rst_n_i,
  narrow_beat_if.responder beat_i,
  narrow_beat_if.requester beat_o
);

  beat_op_e                 op_q    [CutDepth];
  logic [AddrWidth-1:0]     addr_q  [CutDepth];
  logic [BeatDataWidth-1:0] wdata_q [CutDepth];
  logic [BeatStrbWidth-1:0] strb_q  [CutDepth];
  logic [CutPtrWidth-1:0]   wr_ptr_q, rd_ptr_q;
  logic [CutCntWidth-1:0]   count_q;
  logic                     full, push, pop;

  function automatic logic [CutPtrWidth-1:0] next_ptr(input logic [CutPtrWidth-1:0] ptr);
    return (ptr == CutPtrWidth'(CutDepth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign full = (count_q == CutCntWidth'(CutDepth));
  assign push = beat_i.valid && beat_i.ready;
  assign pop  = beat_o.valid && beat_o.ready;

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) wr_ptr_q <= next_ptr(wr_ptr_q);
      if (pop) rd_ptr_q <= next_ptr(rd_ptr_q);
      if (push && !pop) begin
        count_q <= count_q + 1'b1;
      end else if (pop && !push) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      op_q[wr_ptr_q]    <= beat_i.op;
      addr_q[wr_ptr_q]  <= beat_i.addr;
      wdata_q[wr_ptr_q] <= beat_i.wdata;
      strb_q[wr_ptr_q]  <= beat_i.strb;
    end
  end

  assign beat_i.ready = !full;
  assign beat_o.valid = (count_q != '0);
  assign beat_o.op    = op_q[rd_ptr_q];
  assign beat_o.addr  = addr_q[rd_ptr_q];
  assign beat_o.wdata = wdata_q[rd_ptr_q];
  assign beat_o.strb  = strb_q[rd_ptr_q];

  // Response path is not cut
  assign beat_i.rsp_valid = beat_o.rsp_valid;
  assign beat_i.rsp_rdata = beat_o.rsp_rdata;
  assign beat_i.rsp_err   = beat_o.rsp_err;

  // No push while full keeps the count within the depth
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   count_q <= CutCntWidth'(CutDepth));
  // Pointers meet only when empty or full
  assert property (@(posedge clk_i) disable iff (!rst_n_i)
                   (wr_ptr_q == rd_ptr_q) |-> (count_q == '0 || full));

endmodule

// File: verilog/dw_split_stage.sv
/*
  Width split from the 64-bit narrow request port to 32-bit beats.
  One request is in flight at a time; beats are issued per strobe half
  and the two halves of the response are merged before it is returned.
*/

module dw_split_stage
  import tile_ctrl_pkg::*;
(
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       req_valid_i,
  output logic                       req_ready_o,
  input  logic                       req_write_i,
  input  logic [AddrWidth-1:0]       req_addr_i,
  input  logic [NarrowDataWidth-1:0] req_wdata_i,
  input  logic [NarrowStrbWidth-1:0] req_strb_i,
  output logic                       rsp_valid_o,
  input  logic                       rsp_ready_i,
  output logic [NarrowDataWidth-1:0] rsp_rdata_o,
  output logic                       rsp_error_o,
  narrow_beat_if.requester           beat_o
);

  split_state_e                 state_q, state_d;
  logic                         req_ready_q;
  logic                         accept;
  logic                         need_lo, need_hi;
  logic                         issue_lo_q, issue_hi_q;
  logic                         beat_hi;
  logic [1:0]                   left_q;
  logic                         rsp_done;
  logic                         rsp_hi_q;
  logic                         rsp_valid_q;
  logic                         write_q;
  logic [AddrWidth-1:3]         addr_q;
  logic [NarrowDataWidth-1:0]   wdata_q;
  logic [NarrowStrbWidth-1:0]   strb_q;
  logic [NarrowDataWidth-1:0]   rdata_q;
  logic                         err_q;

  assign accept = req_valid_i && req_ready_q;

  // Lower beat also carries writes with an all-zero strobe
  assign need_lo = !req_write_i || (|req_strb_i[BeatStrbWidth-1:0]) ||
                   !(|req_strb_i[NarrowStrbWidth-1:BeatStrbWidth]);
  assign need_hi = !req_write_i || (|req_strb_i[NarrowStrbWidth-1:BeatStrbWidth]);

  assign rsp_done = beat_o.rsp_valid && (left_q == 2'd1);

  always_comb begin
    state_d = state_q;
    case (state_q)
      SPLIT_IDLE: if (accept) state_d = SPLIT_WAIT;
      SPLIT_WAIT: if (rsp_valid_q && rsp_ready_i) state_d = SPLIT_IDLE;
      default:    state_d = SPLIT_IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q     <= SPLIT_IDLE;
      req_ready_q <= 1'b0;
      issue_lo_q  <= 1'b0;
      issue_hi_q  <= 1'b0;
      left_q      <= 2'd0;
      rsp_valid_q <= 1'b0;
    end else begin
      state_q     <= state_d;
      req_ready_q <= (state_d == SPLIT_IDLE);
      if (accept) begin
        issue_lo_q <= need_lo;
        issue_hi_q <= need_hi;
        left_q     <= {1'b0, need_lo} + {1'b0, need_hi};
      end else begin
        if (beat_o.valid && beat_o.ready) begin
          if (issue_lo_q) begin
            issue_lo_q <= 1'b0;
          end else begin
            issue_hi_q <= 1'b0;
          end
        end
        if (beat_o.rsp_valid) begin
          left_q <= left_q - 2'd1;
        end
      end
      if (rsp_done) begin
        rsp_valid_q <= 1'b1;
      end else if (rsp_ready_i) begin
        rsp_valid_q <= 1'b0;
      end
    end
  end

  // Request capture and response assembly
  always_ff @(posedge clk_i) begin
    if (accept) begin
      write_q  <= req_write_i;
      addr_q   <= req_addr_i[AddrWidth-1:3];
      wdata_q  <= req_wdata_i;
      strb_q   <= req_strb_i;
      rsp_hi_q <= !need_lo;
      rdata_q  <= '0;
      err_q    <= 1'b0;
    end else if (beat_o.rsp_valid) begin
      if (rsp_hi_q) begin
        rdata_q[NarrowDataWidth-1:BeatDataWidth] <= beat_o.rsp_rdata;
      end else begin
        rdata_q[BeatDataWidth-1:0] <= beat_o.rsp_rdata;
      end
      err_q    <= err_q | beat_o.rsp_err;
      rsp_hi_q <= 1'b1;
    end
  end

  // Lower half goes first
  assign beat_hi      = !issue_lo_q;
  assign beat_o.valid = issue_lo_q || issue_hi_q;
  assign beat_o.op    = write_q ? BEAT_WRITE : BEAT_READ;
  assign beat_o.addr  = {addr_q, beat_hi, 2'b00};
  assign beat_o.wdata = beat_hi ? wdata_q[NarrowDataWidth-1:BeatDataWidth]
                                : wdata_q[BeatDataWidth-1:0];
  assign beat_o.strb  = beat_hi ? strb_q[NarrowStrbWidth-1:BeatStrbWidth]
                                : strb_q[BeatStrbWidth-1:0];

  assign req_ready_o = req_ready_q;
  assign rsp_valid_o = rsp_valid_q;
  assign rsp_rdata_o = rdata_q;
  assign rsp_error_o = err_q;

  assert property (@(posedge clk_i) disable iff (!rst_n_i) !(rsp_valid_o && req_ready_o));

endmodule

// File: verilog/apb_if.sv
/*
  One APB link from the bridge to the accelerator register block.
  The manager owns select, enable and the payload; the subordinate answers.
*/

interface apb_if
  import tile_ctrl_pkg::*;
();

  logic                     psel;
  logic                     penable;
  logic                     pwrite;
  logic [AddrWidth-1:0]     paddr;
  logic [BeatDataWidth-1:0] pwdata;
  logic [BeatStrbWidth-1:0] pstrb;
  logic [BeatDataWidth-1:0] prdata;
  logic                     pready;
  logic                     pslverr;

  modport manager (
    output psel, penable, pwrite, paddr, pwdata, pstrb,
    input  prdata, pready, pslverr
  );

  modport subordinate (
    input  psel, penable, pwrite, paddr, pwdata, pstrb,
    output prdata, pready, pslverr
  );

endinterface

// File: verilog/narrow_beat_if.sv
/*
  32-bit beat link between pipeline stages. The requester drives a beat
  with valid/ready, the responder returns one in-order response per beat.
*/

interface narrow_beat_if
  import tile_ctrl_pkg::*;
(
  input logic clk_i
);

  logic                     valid;
  logic                     ready;
  beat_op_e                 op;
  logic [AddrWidth-1:0]     addr;
  logic [BeatDataWidth-1:0] wdata;
  logic [BeatStrbWidth-1:0] strb;
  logic                     rsp_valid;
  logic [BeatDataWidth-1:0] rsp_rdata;
  logic                     rsp_err;

  modport requester (
    output valid, op, addr, wdata, strb,
    input  ready, rsp_valid, rsp_rdata, rsp_err
  );

  modport responder (
    input  valid, op, addr, wdata, strb,
    output ready, rsp_valid, rsp_rdata, rsp_err
  );

  // A stalled beat stays put until the responder takes it
  assert property (@(posedge clk_i) valid && !ready |=>
                   valid && $stable({op, addr, wdata, strb}));

endinterface

// File: verilog/tile_ctrl_pkg.sv
/*
  Shared widths, register map, job length and state encodings of the
  accelerator control path. Design files import it in their headers.
*/

package tile_ctrl_pkg;

  // Bus widths
  localparam int unsigned AddrWidth       = 32;
  localparam int unsigned NarrowDataWidth = 64;
  localparam int unsigned NarrowStrbWidth = NarrowDataWidth / 8;
  localparam int unsigned BeatDataWidth   = 32;
  localparam int unsigned BeatStrbWidth   = BeatDataWidth / 8;

  // Accelerator and event lines
  localparam int unsigned NrCores     = 4;
  localparam int unsigned JobCycles   = 8;
  localparam int unsigned JobCntWidth = $clog2(JobCycles);

  // Register cut sizing
  localparam int unsigned CutDepth    = 2;
  localparam int unsigned CutPtrWidth = $clog2(CutDepth);
  localparam int unsigned CutCntWidth = $clog2(CutDepth + 1);

  ////////////////////////////////////////////////////////////////////////////
  // Register map
  ////////////////////////////////////////////////////////////////////////////

  localparam logic [AddrWidth-1:0] RegCtrl     = 32'h0000_0000;
  localparam logic [AddrWidth-1:0] RegStatus   = 32'h0000_0004;
  localparam logic [AddrWidth-1:0] RegOperand0 = 32'h0000_0008;
  localparam logic [AddrWidth-1:0] RegOperand1 = 32'h0000_000C;
  localparam logic [AddrWidth-1:0] RegResult   = 32'h0000_0010;
  localparam logic [AddrWidth-1:0] RegEvtMask  = 32'h0000_0014;
  localparam logic [AddrWidth-1:0] RegEvtClear = 32'h0000_0018;

  typedef enum logic {
    BEAT_READ,
    BEAT_WRITE
  } beat_op_e;

  typedef enum logic {
    SPLIT_IDLE,
    SPLIT_WAIT
  } split_state_e;

  typedef enum logic [1:0] {
    APB_IDLE,
    APB_SETUP,
    APB_ACCESS
  } apb_state_e;

  typedef enum logic {
    JOB_IDLE,
    JOB_RUN
  } job_state_e;

endpackage
